//--- rtl/rv_front_consts.svh
`ifndef RV_FRONT_CONSTS_SVH
`define RV_FRONT_CONSTS_SVH

// Datapath width of instruction words and PC
`define XLEN        32

// Register index and CSR address widths
`define REG_ADDR_W  5
`define CSR_W       12

// Entries in the fetch to decode queue, power of two
`define QUEUE_DEPTH 4

// First fetch address after reset
`define RESET_PC    32'h0000_0000

// Byte step between sequential fetches
`define PC_STEP     4

`endif

//--- rtl/rv_front_pkg.sv
`include "rv_front_consts.svh"

package rv_front_pkg;

    typedef enum logic [6:0] {
        R_TYPE       = 7'b011_0011,
        I_TYPE_A     = 7'b001_0011,   // Immediate arithmetic
        I_TYPE_L     = 7'b000_0011,   // Loads
        I_TYPE_JALR  = 7'b110_0111,
        I_TYPE_ECALL = 7'b111_0011,   // ECALL, EBREAK and CSR ops
        S_TYPE       = 7'b010_0011,
        B_TYPE       = 7'b110_0011,
        U_TYPE_AUIPC = 7'b001_0111,
        U_TYPE_LUI   = 7'b011_0111,
        J_TYPE_LK    = 7'b110_1111,
        F_TYPE_FENCE = 7'b000_1111
    } opcode_e;

    typedef enum logic [3:0] {
        FMT_R,
        FMT_I,
        FMT_I_SYS,
        FMT_S,
        FMT_B,
        FMT_U,
        FMT_J,
        FMT_F,
        FMT_UNRECOGNIZED
    } inst_fmt_e;

    typedef enum logic [5:0] {
        OP_ADD, OP_SUB, OP_SLL, OP_SLT, OP_SLTU,
        OP_XOR, OP_SRL, OP_SRA, OP_OR, OP_AND,
        OP_ADDI, OP_SLTI, OP_SLTIU, OP_XORI, OP_ORI,
        OP_ANDI, OP_SLLI, OP_SRLI, OP_SRAI,
        OP_LB, OP_LH, OP_LW, OP_LBU, OP_LHU,
        OP_JALR,
        OP_ECALL, OP_EBREAK,
        OP_CSRRW, OP_CSRRS, OP_CSRRC,
        OP_CSRRWI, OP_CSRRSI, OP_CSRRCI,
        OP_SB, OP_SH, OP_SW,
        OP_BEQ, OP_BNE, OP_BLT, OP_BGE, OP_BLTU, OP_BGEU,
        OP_AUIPC, OP_LUI, OP_JAL,
        OP_FENCE, OP_FENCEI,
        OP_UNKNOWN
    } inst_op_e;

    typedef struct packed {
        logic [`XLEN-1:0] pc;
        logic [`XLEN-1:0] inst;
    } fetch_entry_t;

    typedef struct packed {
        logic [`XLEN-1:0]       pc;
        opcode_e                opcode;
        inst_fmt_e              fmt;
        inst_op_e               op;
        logic [`REG_ADDR_W-1:0] rd;
        logic [`REG_ADDR_W-1:0] rs1;
        logic [`REG_ADDR_W-1:0] rs2;
        logic [2:0]             fun3;
        logic [6:0]             fun7;
        logic [`CSR_W-1:0]      csr;   // Zero outside system ops
        logic [`XLEN-1:0]       imm;
    } decoded_inst_t;

endpackage

//--- rtl/inst_fetch.sv
`include "rv_front_consts.svh"

module inst_fetch
    import rv_front_pkg::*;
(
    input  logic             i_clk,
    input  logic             arst_n_i,
    input  logic             fetch_en_i,
    output logic [`XLEN-1:0] imem_addr_o,
    output logic             imem_rd_o,
    input  logic [`XLEN-1:0] imem_rdata_i,
    input  logic             q_full_i,
    input  logic             q_almost_full_i,
    output logic             q_push_o,
    output fetch_entry_t     q_entry_o
);

    logic [`XLEN-1:0] pc_q;
    logic [`XLEN-1:0] inflight_pc_q;   // Address of the outstanding read
    logic             inflight_q;
    logic             live_q;          // Set one cycle after reset release

    // A read in flight will still push, so stop one entry early
    assign imem_rd_o = live_q & fetch_en_i & ~q_full_i
                     & ~(q_almost_full_i & inflight_q);
    assign imem_addr_o = pc_q;

    assign q_push_o       = inflight_q;   // Data returns this cycle
    assign q_entry_o.pc   = inflight_pc_q;
    assign q_entry_o.inst = imem_rdata_i;

    always_ff @(posedge i_clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            pc_q       <= `RESET_PC;
            inflight_q <= 1'b0;
            live_q     <= 1'b0;
        end else begin
            live_q     <= 1'b1;
            inflight_q <= imem_rd_o;
            if (imem_rd_o) begin
                pc_q <= pc_q + `XLEN'(`PC_STEP);
            end
        end
    end

    always_ff @(posedge i_clk) begin
        if (imem_rd_o) begin
            inflight_pc_q <= pc_q;
        end
    end

endmodule

//--- rtl/inst_queue.sv
`include "rv_front_consts.svh"

module inst_queue #(
    parameter type entry_t = logic [`XLEN-1:0],
    parameter int  DEPTH   = `QUEUE_DEPTH        // Power of two, at least 2
) (
    input  logic   i_clk,
    input  logic   arst_n_i,
    input  logic   push_i,
    input  entry_t entry_i,
    input  logic   pop_i,
    output entry_t head_o,
    output logic   empty_o,
    output logic   full_o,
    output logic   almost_full_o
);

    localparam int PTR_W = $clog2(DEPTH);
    localparam int CNT_W = PTR_W + 1;

    entry_t           mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr_q;
    logic [PTR_W-1:0] rd_ptr_q;
    logic [CNT_W-1:0] count_q;
    logic             do_push;
    logic             do_pop;

    assign do_push = push_i & ~full_o;
    assign do_pop  = pop_i & ~empty_o;

    assign head_o        = mem[rd_ptr_q];
    assign empty_o       = (count_q == '0);
    assign full_o        = (count_q == CNT_W'(DEPTH));
    assign almost_full_o = (count_q >= CNT_W'(DEPTH - 1));

    always_ff @(posedge i_clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr_q <= wr_ptr_q + 1'b1;   // Wraps at DEPTH
            end
            if (do_pop) begin
                rd_ptr_q <= rd_ptr_q + 1'b1;
            end
            case ({do_push, do_pop})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: count_q <= count_q;   // Both or neither
            endcase
        end
    end

    always_ff @(posedge i_clk) begin
        if (do_push) begin
            mem[wr_ptr_q] <= entry_i;
        end
    end

endmodule

//--- rtl/inst_decode.sv
`include "rv_front_consts.svh"

module inst_decode
    import rv_front_pkg::*;
(
    input  logic          i_clk,
    input  logic          arst_n_i,
    input  logic          decode_en_i,
    input  logic          q_empty_i,
    input  fetch_entry_t  q_head_i,
    output logic          q_pop_o,
    output logic          dec_valid_o,
    output decoded_inst_t dec_o
);

    logic [`XLEN-1:0] inst;
    opcode_e          opcode;
    logic [2:0]       fun3;
    logic [6:0]       fun7;
    decoded_inst_t    dec_d;

    assign inst    = q_head_i.inst;
    assign opcode  = opcode_e'(inst[6:0]);
    assign fun3    = inst[14:12];
    assign fun7    = inst[31:25];
    assign q_pop_o = decode_en_i & ~q_empty_i;

    // Format and field extraction
    always_comb begin
        dec_d        = '0;
        dec_d.pc     = q_head_i.pc;
        dec_d.opcode = opcode;
        dec_d.fmt    = FMT_UNRECOGNIZED;
        case (opcode)
            R_TYPE: begin
                dec_d.fmt  = FMT_R;
                dec_d.rd   = inst[11:7];
                dec_d.fun3 = fun3;
                dec_d.rs1  = inst[19:15];
                dec_d.rs2  = inst[24:20];
                dec_d.fun7 = fun7;
            end
            I_TYPE_A, I_TYPE_L, I_TYPE_JALR: begin
                dec_d.fmt  = FMT_I;
                dec_d.rd   = inst[11:7];
                dec_d.fun3 = fun3;
                dec_d.rs1  = inst[19:15];
                dec_d.fun7 = fun7;   // Shift type lives here
                dec_d.imm  = {{20{inst[31]}}, inst[31:20]};
            end
            I_TYPE_ECALL: begin
                dec_d.fmt  = FMT_I_SYS;
                dec_d.rd   = inst[11:7];
                dec_d.fun3 = fun3;
                dec_d.rs1  = inst[19:15];
                dec_d.csr  = inst[31:20];
                dec_d.imm  = {{20{inst[31]}}, inst[31:20]};
            end
            S_TYPE: begin
                dec_d.fmt  = FMT_S;
                dec_d.fun3 = fun3;
                dec_d.rs1  = inst[19:15];
                dec_d.rs2  = inst[24:20];
                dec_d.imm  = {{20{inst[31]}}, inst[31:25], inst[11:7]};
            end
            B_TYPE: begin
                dec_d.fmt  = FMT_B;
                dec_d.fun3 = fun3;
                dec_d.rs1  = inst[19:15];
                dec_d.rs2  = inst[24:20];
                dec_d.imm  = {{20{inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};
            end
            U_TYPE_AUIPC, U_TYPE_LUI: begin
                dec_d.fmt = FMT_U;
                dec_d.rd  = inst[11:7];
                dec_d.imm = {inst[31:12], 12'b0};
            end
            J_TYPE_LK: begin
                dec_d.fmt = FMT_J;
                dec_d.rd  = inst[11:7];
                dec_d.imm = {{12{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};
            end
            F_TYPE_FENCE: begin
                dec_d.fmt  = FMT_F;
                dec_d.rd   = inst[11:7];
                dec_d.fun3 = fun3;
                dec_d.rs1  = inst[19:15];
                dec_d.rs2  = inst[24:20];
                dec_d.fun7 = fun7;
            end
            default: ;   // Unknown opcode, all fields zero
        endcase

        // Operation selection
        dec_d.op = OP_UNKNOWN;
        case (opcode)
            R_TYPE: begin
                case ({fun7, fun3})
                    {7'b000_0000, 3'b000}: dec_d.op = OP_ADD;
                    {7'b010_0000, 3'b000}: dec_d.op = OP_SUB;
                    {7'b000_0000, 3'b001}: dec_d.op = OP_SLL;
                    {7'b000_0000, 3'b010}: dec_d.op = OP_SLT;
                    {7'b000_0000, 3'b011}: dec_d.op = OP_SLTU;
                    {7'b000_0000, 3'b100}: dec_d.op = OP_XOR;
                    {7'b000_0000, 3'b101}: dec_d.op = OP_SRL;
                    {7'b010_0000, 3'b101}: dec_d.op = OP_SRA;
                    {7'b000_0000, 3'b110}: dec_d.op = OP_OR;
                    {7'b000_0000, 3'b111}: dec_d.op = OP_AND;
                    default:               dec_d.op = OP_UNKNOWN;
                endcase
            end
            I_TYPE_A: begin
                case (fun3)
                    3'b000: dec_d.op = OP_ADDI;
                    3'b010: dec_d.op = OP_SLTI;
                    3'b011: dec_d.op = OP_SLTIU;
                    3'b100: dec_d.op = OP_XORI;
                    3'b110: dec_d.op = OP_ORI;
                    3'b111: dec_d.op = OP_ANDI;
                    3'b001: dec_d.op = (fun7 == 7'b000_0000) ? OP_SLLI : OP_UNKNOWN;
                    default: begin
                        if (fun7 == 7'b000_0000) begin
                            dec_d.op = OP_SRLI;
                        end else if (fun7 == 7'b010_0000) begin
                            dec_d.op = OP_SRAI;
                        end
                    end
                endcase
            end
            I_TYPE_L: begin
                case (fun3)
                    3'b000:  dec_d.op = OP_LB;
                    3'b001:  dec_d.op = OP_LH;
                    3'b010:  dec_d.op = OP_LW;
                    3'b100:  dec_d.op = OP_LBU;
                    3'b101:  dec_d.op = OP_LHU;
                    default: dec_d.op = OP_UNKNOWN;
                endcase
            end
            I_TYPE_JALR: dec_d.op = (fun3 == 3'b000) ? OP_JALR : OP_UNKNOWN;
            I_TYPE_ECALL: begin
                case (fun3)
                    3'b000:  dec_d.op = inst[20] ? OP_EBREAK : OP_ECALL;
                    3'b001:  dec_d.op = OP_CSRRW;
                    3'b010:  dec_d.op = OP_CSRRS;
                    3'b011:  dec_d.op = OP_CSRRC;
                    3'b101:  dec_d.op = OP_CSRRWI;
                    3'b110:  dec_d.op = OP_CSRRSI;
                    3'b111:  dec_d.op = OP_CSRRCI;
                    default: dec_d.op = OP_UNKNOWN;
                endcase
            end
            S_TYPE: begin
                case (fun3)
                    3'b000:  dec_d.op = OP_SB;
                    3'b001:  dec_d.op = OP_SH;
                    3'b010:  dec_d.op = OP_SW;
                    default: dec_d.op = OP_UNKNOWN;
                endcase
            end
            B_TYPE: begin
                case (fun3)
                    3'b000:  dec_d.op = OP_BEQ;
                    3'b001:  dec_d.op = OP_BNE;
                    3'b100:  dec_d.op = OP_BLT;
                    3'b101:  dec_d.op = OP_BGE;
                    3'b110:  dec_d.op = OP_BLTU;
                    3'b111:  dec_d.op = OP_BGEU;
                    default: dec_d.op = OP_UNKNOWN;
                endcase
            end
            U_TYPE_AUIPC: dec_d.op = OP_AUIPC;
            U_TYPE_LUI:   dec_d.op = OP_LUI;
            J_TYPE_LK:    dec_d.op = OP_JAL;
            F_TYPE_FENCE: begin
                case (fun3)
                    3'b000:  dec_d.op = OP_FENCE;
                    3'b001:  dec_d.op = OP_FENCEI;
                    default: dec_d.op = OP_UNKNOWN;
                endcase
            end
            default: dec_d.op = OP_UNKNOWN;
        endcase
    end

    always_ff @(posedge i_clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            dec_valid_o <= 1'b0;
        end else begin
            dec_valid_o <= q_pop_o;   // One pulse per popped entry
        end
    end

    always_ff @(posedge i_clk) begin
        if (q_pop_o) begin
            dec_o <= dec_d;
        end
    end

endmodule

//--- rtl/rv_front_top.sv
`include "rv_front_consts.svh"

module rv_front_top
    import rv_front_pkg::*;
(
    input  logic             i_clk,
    input  logic             arst_n_i,
    input  logic             fetch_en_i,
    input  logic             decode_en_i,
    output logic [`XLEN-1:0] imem_addr_o,
    output logic             imem_rd_o,
    input  logic [`XLEN-1:0] imem_rdata_i,
    output logic             dec_valid_o,
    output decoded_inst_t    dec_o
);

    fetch_entry_t push_entry;
    fetch_entry_t head_entry;
    logic         q_push;
    logic         q_pop;
    logic         q_empty;
    logic         q_full;
    logic         q_almost_full;

    inst_fetch u_fetch (
        .i_clk           (i_clk),
        .arst_n_i        (arst_n_i),
        .fetch_en_i      (fetch_en_i),
        .imem_addr_o     (imem_addr_o),
        .imem_rd_o       (imem_rd_o),
        .imem_rdata_i    (imem_rdata_i),
        .q_full_i        (q_full),
        .q_almost_full_i (q_almost_full),
        .q_push_o        (q_push),
        .q_entry_o       (push_entry)
    );

    inst_queue #(
        .entry_t (fetch_entry_t),
        .DEPTH   (`QUEUE_DEPTH)
    ) u_queue (
        .i_clk         (i_clk),
        .arst_n_i      (arst_n_i),
        .push_i        (q_push),
        .entry_i       (push_entry),
        .pop_i         (q_pop),
        .head_o        (head_entry),
        .empty_o       (q_empty),
        .full_o        (q_full),
        .almost_full_o (q_almost_full)
    );

    inst_decode u_decode (
        .i_clk       (i_clk),
        .arst_n_i    (arst_n_i),
        .decode_en_i (decode_en_i),
        .q_empty_i   (q_empty),
        .q_head_i    (head_entry),
        .q_pop_o     (q_pop),
        .dec_valid_o (dec_valid_o),
        .dec_o       (dec_o)
    );

endmodule

//--- verif/tb_decode_model.svh
`ifndef TB_DECODE_MODEL_SVH
`define TB_DECODE_MODEL_SVH

// Reference RV32I decode, built from the opcode tables
function automatic decoded_inst_t model_decode(input logic [31:0] pc, input logic [31:0] w);
    inst_op_e      r_ops [8]   = '{OP_ADD, OP_SLL, OP_SLT, OP_SLTU,
                                   OP_XOR, OP_SRL, OP_OR, OP_AND};
    inst_op_e      i_ops [8]   = '{OP_ADDI, OP_SLLI, OP_SLTI, OP_SLTIU,
                                   OP_XORI, OP_SRLI, OP_ORI, OP_ANDI};
    inst_op_e      ld_ops [8]  = '{OP_LB, OP_LH, OP_LW, OP_UNKNOWN,
                                   OP_LBU, OP_LHU, OP_UNKNOWN, OP_UNKNOWN};
    inst_op_e      sys_ops [8] = '{OP_ECALL, OP_CSRRW, OP_CSRRS, OP_CSRRC,
                                   OP_UNKNOWN, OP_CSRRWI, OP_CSRRSI, OP_CSRRCI};
    inst_op_e      st_ops [8]  = '{OP_SB, OP_SH, OP_SW, OP_UNKNOWN,
                                   OP_UNKNOWN, OP_UNKNOWN, OP_UNKNOWN, OP_UNKNOWN};
    inst_op_e      br_ops [8]  = '{OP_BEQ, OP_BNE, OP_UNKNOWN, OP_UNKNOWN,
                                   OP_BLT, OP_BGE, OP_BLTU, OP_BGEU};
    decoded_inst_t d;
    logic [2:0]    f3;
    logic [6:0]    f7;
    logic [3:0]    fmt_v;
    logic [4:0]    used;   // rd rs1 rs2 fun3 fun7
    logic [31:0]   sext;
    d        = '0;
    f3       = w[14:12];
    f7       = w[31:25];
    sext     = {{20{w[31]}}, w[31:20]};
    d.pc     = pc;
    d.opcode = opcode_e'(w[6:0]);
    case (w[6:0])
        7'h33:               {fmt_v, used} = {FMT_R, 5'b11111};
        7'h13, 7'h03, 7'h67: {fmt_v, used} = {FMT_I, 5'b11011};
        7'h73:               {fmt_v, used} = {FMT_I_SYS, 5'b11010};
        7'h23:               {fmt_v, used} = {FMT_S, 5'b01110};
        7'h63:               {fmt_v, used} = {FMT_B, 5'b01110};
        7'h17, 7'h37:        {fmt_v, used} = {FMT_U, 5'b10000};
        7'h6f:               {fmt_v, used} = {FMT_J, 5'b10000};
        7'h0f:               {fmt_v, used} = {FMT_F, 5'b11111};
        default:             {fmt_v, used} = {FMT_UNRECOGNIZED, 5'b00000};
    endcase
    d.fmt  = inst_fmt_e'(fmt_v);
    d.rd   = used[4] ? w[11:7] : 5'd0;
    d.rs1  = used[3] ? w[19:15] : 5'd0;
    d.rs2  = used[2] ? w[24:20] : 5'd0;
    d.fun3 = used[1] ? f3 : 3'd0;
    d.fun7 = used[0] ? f7 : 7'd0;
    d.csr  = (d.fmt == FMT_I_SYS) ? w[31:20] : 12'd0;
    case (d.fmt)
        FMT_I, FMT_I_SYS: d.imm = sext;
        FMT_S:            d.imm = {sext[31:5], w[11:7]};
        FMT_B:            d.imm = {sext[31:12], w[7], w[30:25], w[11:8], 1'b0};
        FMT_U:            d.imm = {w[31:12], 12'h000};
        FMT_J:            d.imm = {sext[31:20], w[19:12], w[20], w[30:21], 1'b0};
        default:          d.imm = '0;
    endcase
    case (w[6:0])
        7'h33:   d.op = (f7 == 7'h00) ? r_ops[f3]
                      : (f7 == 7'h20 && f3 == 3'd0) ? OP_SUB
                      : (f7 == 7'h20 && f3 == 3'd5) ? OP_SRA : OP_UNKNOWN;
        7'h13:   d.op = (f3 == 3'd1 && f7 != 7'h00) ? OP_UNKNOWN
                      : (f3 == 3'd5 && f7 == 7'h20) ? OP_SRAI
                      : (f3 == 3'd5 && f7 != 7'h00) ? OP_UNKNOWN : i_ops[f3];
        7'h03:   d.op = ld_ops[f3];
        7'h67:   d.op = (f3 == 3'd0) ? OP_JALR : OP_UNKNOWN;
        7'h73:   d.op = (f3 == 3'd0 && w[20]) ? OP_EBREAK : sys_ops[f3];
        7'h23:   d.op = st_ops[f3];
        7'h63:   d.op = br_ops[f3];
        7'h17:   d.op = OP_AUIPC;
        7'h37:   d.op = OP_LUI;
        7'h6f:   d.op = OP_JAL;
        7'h0f:   d.op = (f3 == 3'd0) ? OP_FENCE : (f3 == 3'd1) ? OP_FENCEI : OP_UNKNOWN;
        default: d.op = OP_UNKNOWN;
    endcase
    return d;
endfunction

// Low words sweep opcode, fun3 and fun7, the rest mostly known opcodes
function automatic logic [31:0] gen_inst(input int idx);
    logic [6:0]  known [11] = '{7'h33, 7'h13, 7'h03, 7'h67, 7'h73, 7'h23,
                                7'h63, 7'h17, 7'h37, 7'h6f, 7'h0f};
    logic [31:0] w;
    w = $urandom;
    if (idx < 176) begin
        w[6:0]   = known[idx / 16];
        w[14:12] = idx[2:0];
        w[31:25] = idx[3] ? 7'h20 : 7'h00;
        w[20]    = idx[3];   // ECALL or EBREAK
    end else if ($urandom_range(0, 7) != 0) begin
        w[6:0] = known[$urandom_range(0, 10)];
        if ($urandom_range(0, 3) < 2) begin
            w[31:25] = 7'h00;
        end else if ($urandom_range(0, 1) == 0) begin
            w[31:25] = 7'h20;
        end
    end
    return w;
endfunction

`endif

//--- verif/tb_rv_front_top.sv
`include "rv_front_consts.svh"

module tb_rv_front_top
    import rv_front_pkg::*;
();

    timeunit 1ns;
    timeprecision 100ps;

    localparam int NUM_INSTS  = 2000;
    localparam int MAX_CYCLES = 40000;

    logic             clk = 1'b0;
    logic             arst_n;
    logic             fetch_en;
    logic             decode_en;
    logic [`XLEN-1:0] imem_addr;
    logic             imem_rd;
    logic [`XLEN-1:0] imem_rdata;
    logic             dec_valid;
    decoded_inst_t    dec;

    logic [31:0]      imem [256];
    int               cycle = 0;
    int               n_decoded = 0;
    int               run_left = 0;
    int               last_valid = 0;
    int               rd_cycles [$];   // Strobe cycle of each word not yet decoded
    bit               den_at [int];    // decode_en_i level per cycle
    logic [31:0]      exp_rd_addr = `RESET_PC;
    logic [31:0]      exp_dec_pc = `RESET_PC;

    `include "tb_decode_model.svh"

    rv_front_top dut_i (
        .i_clk        (clk),
        .arst_n_i     (arst_n),
        .fetch_en_i   (fetch_en),
        .decode_en_i  (decode_en),
        .imem_addr_o  (imem_addr),
        .imem_rd_o    (imem_rd),
        .imem_rdata_i (imem_rdata),
        .dec_valid_o  (dec_valid),
        .dec_o        (dec)
    );

    always #2 clk = ~clk;

    always @(posedge clk) begin
        if (imem_rd) begin
            imem_rdata <= imem[imem_addr[9:2]];   // One cycle read latency
        end
    end

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("Regression failed");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [63:0] got,
                               input logic [63:0] exp);
        assert (got === exp) else begin
            abort_run($sformatf("[FAIL] t=%0t %s: got %0h, expected %0h",
                                $time, name, got, exp));
        end
    endtask

    // Decode enable comes in runs, long low runs fill the queue
    task automatic drive_enables();
        fetch_en <= ($urandom_range(0, 4) != 0);
        if (run_left == 0) begin
            run_left  <= $urandom_range(1, 30);
            decode_en <= ($urandom_range(0, 3) != 0);
        end else begin
            run_left <= run_left - 1;
        end
    endtask

    initial begin
        void'($urandom(32'haaafd9fa));
        fetch_en   = 1'b1;   // Enabled in reset, fetch must still stay idle
        decode_en  = 1'b1;
        imem_rdata = '0;
        arst_n     = 1'b0;
        for (int i = 0; i < 256; i++) begin
            imem[i] = gen_inst(i);
        end
        repeat (3) @(posedge clk);
        arst_n <= 1'b1;
        while (n_decoded < NUM_INSTS && cycle < MAX_CYCLES) begin
            @(posedge clk);
            drive_enables();
        end
        if (n_decoded >= NUM_INSTS) begin
            $display("Regression passed");
            $finish;
        end else begin
            abort_run("Timeout: not all instructions were decoded within the cycle limit");
        end
    end

    always @(negedge clk) begin : monitor
        int            rd_c;
        int            k;
        decoded_inst_t exp_d;
        if (!arst_n || cycle == 0) begin
            check_value("imem_rd_o", imem_rd, 0);   // Also idle one cycle after reset
            check_value("dec_valid_o", dec_valid, 0);
        end
        if (arst_n) begin
            den_at[cycle] = decode_en;
            if (dec_valid) begin
                assert (rd_cycles.size() > 0) else begin
                    abort_run("dec_valid_o pulsed with no fetched word outstanding");
                end
                rd_c = rd_cycles.pop_front();
                // Queued one cycle after the read, popped at the next enabled free cycle
                k = (rd_c + 2 > last_valid) ? rd_c + 2 : last_valid;
                while (k < cycle && !den_at[k]) begin
                    k++;
                end
                check_value("dec_valid_o cycle", cycle, k + 1);
                last_valid = cycle;
                exp_d = model_decode(exp_dec_pc, imem[exp_dec_pc[9:2]]);
                check_value("dec_o.pc", dec.pc, exp_d.pc);
                check_value("dec_o.opcode", dec.opcode, exp_d.opcode);
                check_value("dec_o.fmt", dec.fmt, exp_d.fmt);
                check_value("dec_o.op", dec.op, exp_d.op);
                check_value("dec_o.rd", dec.rd, exp_d.rd);
                check_value("dec_o.rs1", dec.rs1, exp_d.rs1);
                check_value("dec_o.rs2", dec.rs2, exp_d.rs2);
                check_value("dec_o.fun3", dec.fun3, exp_d.fun3);
                check_value("dec_o.fun7", dec.fun7, exp_d.fun7);
                check_value("dec_o.csr", dec.csr, exp_d.csr);
                check_value("dec_o.imm", dec.imm, exp_d.imm);
                exp_dec_pc = exp_dec_pc + `PC_STEP;
                n_decoded++;
            end
            assert (rd_cycles.size() <= `QUEUE_DEPTH) else begin
                abort_run("More words fetched than the queue can hold");
            end
            if (!decode_en && rd_cycles.size() == `QUEUE_DEPTH) begin
                check_value("imem_rd_o with queue full", imem_rd, 0);
            end
            if (imem_rd) begin
                check_value("imem_addr_o", imem_addr, exp_rd_addr);
                exp_rd_addr = exp_rd_addr + `PC_STEP;
                rd_cycles.push_back(cycle);
            end
            cycle++;
        end
    end

endmodule

//--- project.f
+incdir+rtl
+incdir+verif
rtl/rv_front_pkg.sv
rtl/inst_fetch.sv
rtl/inst_queue.sv
rtl/inst_decode.sv
rtl/rv_front_top.sv
verif/tb_rv_front_top.sv

//--- run_sim.sh
#!/bin/sh
# Build with Verilator, run, then look for the pass line in the log
cd "$(dirname "$0")" \
    && rm -f sim.log \
    && verilator --binary --timing -Wno-fatal --top-module tb_rv_front_top \
        -f project.f -o sim_rv_front \
    && { ./obj_dir/sim_rv_front > sim.log 2>&1 || true; } \
    && grep -q "Regression passed" sim.log \
    && echo "Simulation PASSED" \
    || { cat sim.log 2>/dev/null; echo "Simulation FAILED"; exit 1; }
